// File: hw/exe_pkg.sv
package exe_pkg;

    localparam int XLEN     = 32;
    localparam int PRF_ID_W = 6;
    localparam int ROB_ID_W = 5;

    typedef logic [XLEN-1:0]     t_rv_reg_data;
    typedef logic [PRF_ID_W-1:0] t_prf_id;
    typedef logic [ROB_ID_W-1:0] t_rob_id;

    typedef enum logic [4:0] {
        U_ADD,
        U_SUB,
        U_AND,
        U_OR,
        U_XOR,
        U_SLL,
        U_SRL,
        U_SRA,
        U_SLT,
        U_SLTU,
        U_BEQ,
        U_BNE,
        U_BLT,
        U_BGE,
        U_BLTU,
        U_BGEU,
        U_JAL
    } t_uop;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_REG,
        OP_IMM
    } t_optype;

    // Decoded micro-op with imm already sign-extended
    typedef struct packed {
        logic         valid;
        t_uop         uop;
        t_optype      src2_optype;
        t_optype      dst_optype;
        t_rv_reg_data imm;
        t_rv_reg_data pc;
        logic         pred_taken;
        logic         mispred;
    } t_uinstr;

    typedef struct packed {
        t_uinstr uinstr;
        t_prf_id psrc1;
        t_prf_id psrc2;
        t_prf_id pdst;
        t_rob_id robid;
    } t_iss_pkt;

    // Issue packet after register read
    typedef struct packed {
        t_uinstr      uinstr;
        t_prf_id      psrc1;
        t_prf_id      psrc2;
        t_prf_id      pdst;
        t_rob_id      robid;
        t_rv_reg_data src1_val;
        t_rv_reg_data src2_val;
    } t_exe_iss_pkt;

    typedef struct packed {
        t_prf_id      pdst;
        t_rv_reg_data data;
    } t_prf_wr_pkt;

    typedef struct packed {
        logic    valid;
        logic    mispred;
        t_rob_id robid;
    } t_rob_complete_pkt;

    typedef struct packed {
        logic         valid;
        t_rob_id      robid;
        t_rv_reg_data target;
    } t_br_mispred_pkt;

    typedef struct packed {
        logic         valid;
        t_rv_reg_data pc;
    } t_nuke_pkt;

endpackage

// File: hw/ialu.sv
module ialu
    import exe_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,

    input  t_uinstr      uinstr_ex0,
    input  t_rv_reg_data src1val_ex0,
    input  t_rv_reg_data src2val_ex0,

    output logic         resvld_ex0,
    output t_rv_reg_data result_ex0
);

    logic [4:0] shamt_ex0;
    logic       is_alu_ex0;

    assign shamt_ex0 = src2val_ex0[4:0];

    always_comb begin
        is_alu_ex0 = uinstr_ex0.uop inside {
            U_ADD, U_SUB, U_AND, U_OR, U_XOR,
            U_SLL, U_SRL, U_SRA, U_SLT, U_SLTU
        };
    end

    assign resvld_ex0 = uinstr_ex0.valid & is_alu_ex0;

    always_comb begin
        result_ex0 = '0;
        case (uinstr_ex0.uop)
            U_ADD: begin
                result_ex0 = src1val_ex0 + src2val_ex0;
            end
            U_SUB: begin
                result_ex0 = src1val_ex0 - src2val_ex0;
            end
            U_AND: begin
                result_ex0 = src1val_ex0 & src2val_ex0;
            end
            U_OR: begin
                result_ex0 = src1val_ex0 | src2val_ex0;
            end
            U_XOR: begin
                result_ex0 = src1val_ex0 ^ src2val_ex0;
            end
            U_SLL: begin
                result_ex0 = src1val_ex0 << shamt_ex0;
            end
            U_SRL: begin
                result_ex0 = src1val_ex0 >> shamt_ex0;
            end
            U_SRA: begin
                // Arithmetic shift keeps the sign bit
                result_ex0 = t_rv_reg_data'($signed(src1val_ex0) >>> shamt_ex0);
            end
            U_SLT: begin
                result_ex0 = {{(XLEN-1){1'b0}}, $signed(src1val_ex0) < $signed(src2val_ex0)};
            end
            U_SLTU: begin
                result_ex0 = {{(XLEN-1){1'b0}}, src1val_ex0 < src2val_ex0};
            end
            default: begin
                result_ex0 = '0;
            end
        endcase
    end

endmodule

// File: hw/ibr.sv
module ibr
    import exe_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,

    input  t_exe_iss_pkt    iss_pkt_ex0,
    input  t_rv_reg_data    src1val_ex0,
    input  t_rv_reg_data    src2val_ex0,

    output logic            resvld_ex0,
    output t_rv_reg_data    link_ex0,
    output t_br_mispred_pkt br_mispred_ex0
);

    t_uinstr      uinstr_ex0;
    logic         is_br_ex0;
    logic         is_jal_ex0;
    logic         taken_ex0;
    t_rv_reg_data target_ex0;

    assign uinstr_ex0 = iss_pkt_ex0.uinstr;

    always_comb begin
        is_br_ex0  = uinstr_ex0.uop inside {U_BEQ, U_BNE, U_BLT, U_BGE, U_BLTU, U_BGEU};
        is_jal_ex0 = uinstr_ex0.uop == U_JAL;
    end

    // Actual direction
    always_comb begin
        case (uinstr_ex0.uop)
            U_BEQ:   taken_ex0 = src1val_ex0 == src2val_ex0;
            U_BNE:   taken_ex0 = src1val_ex0 != src2val_ex0;
            U_BLT:   taken_ex0 = $signed(src1val_ex0) < $signed(src2val_ex0);
            U_BGE:   taken_ex0 = $signed(src1val_ex0) >= $signed(src2val_ex0);
            U_BLTU:  taken_ex0 = src1val_ex0 < src2val_ex0;
            U_BGEU:  taken_ex0 = src1val_ex0 >= src2val_ex0;
            U_JAL:   taken_ex0 = 1'b1;
            default: taken_ex0 = 1'b0;
        endcase
    end

    assign target_ex0 = uinstr_ex0.pc + uinstr_ex0.imm;
    assign link_ex0   = uinstr_ex0.pc + t_rv_reg_data'(4);

    // Only jal produces a register result
    assign resvld_ex0 = uinstr_ex0.valid & is_jal_ex0;

    always_comb begin
        br_mispred_ex0.valid  = uinstr_ex0.valid & (is_br_ex0 | is_jal_ex0)
                              & (taken_ex0 != uinstr_ex0.pred_taken);
        br_mispred_ex0.robid  = iss_pkt_ex0.robid;
        br_mispred_ex0.target = taken_ex0 ? target_ex0 : link_ex0;
    end

endmodule

// File: hw/exe.sv
module exe
    import exe_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  t_nuke_pkt         nuke,

    input  t_exe_iss_pkt      iss_pkt_ex0,

    output t_br_mispred_pkt   br_mispred_ex0,

    output logic              iprf_wr_en_ex1,
    output t_prf_wr_pkt       iprf_wr_pkt_ex1,

    output t_rob_complete_pkt complete_ex1
);

    t_uinstr         uinstr_ex0;
    t_uinstr         uinstr_ql_ex0;
    t_rv_reg_data    src1val_ex0;
    t_rv_reg_data    src2val_ex0;
    t_rv_reg_data    result_ex0;

    logic            ialu_resvld_ex0;
    t_rv_reg_data    ialu_result_ex0;
    logic            ibr_resvld_ex0;
    t_rv_reg_data    ibr_link_ex0;
    t_br_mispred_pkt ibr_mispred_ex0;

    logic            valid_ex1;
    logic            live_ex1;
    t_uinstr         uinstr_ex1;
    t_rob_id         robid_ex1;
    t_prf_id         pdst_ex1;
    t_rv_reg_data    result_ex1;

    assign uinstr_ex0 = iss_pkt_ex0.uinstr;

    always_comb begin
        uinstr_ql_ex0         = uinstr_ex0;
        uinstr_ql_ex0.mispred = ibr_mispred_ex0.valid;
    end

    // Operand select
    assign src1val_ex0 = iss_pkt_ex0.src1_val;

    always_comb begin
        case (uinstr_ex0.src2_optype)
            OP_REG:  src2val_ex0 = iss_pkt_ex0.src2_val;
            OP_IMM:  src2val_ex0 = uinstr_ex0.imm;
            default: src2val_ex0 = '0;
        endcase
    end

    ialu u_ialu (
        .clk,
        .arst_n,
        .uinstr_ex0,
        .src1val_ex0,
        .src2val_ex0,
        .resvld_ex0 (ialu_resvld_ex0),
        .result_ex0 (ialu_result_ex0)
    );

    ibr u_ibr (
        .clk,
        .arst_n,
        .iss_pkt_ex0,
        .src1val_ex0,
        .src2val_ex0,
        .resvld_ex0     (ibr_resvld_ex0),
        .link_ex0       (ibr_link_ex0),
        .br_mispred_ex0 (ibr_mispred_ex0)
    );

    assign br_mispred_ex0 = ibr_mispred_ex0;

    always_comb begin
        result_ex0 = (ialu_resvld_ex0 ? ialu_result_ex0 : '0)
                   | (ibr_resvld_ex0  ? ibr_link_ex0    : '0);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_ex1 <= 1'b0;
        end else begin
            valid_ex1 <= uinstr_ql_ex0.valid & ~nuke.valid;
        end
    end

    always_ff @(posedge clk) begin
        uinstr_ex1 <= uinstr_ql_ex0;
        robid_ex1  <= iss_pkt_ex0.robid;
        pdst_ex1   <= iss_pkt_ex0.pdst;
        result_ex1 <= result_ex0;
    end

    // Op sitting in EX1 during a nuke is younger than the flushing branch
    assign live_ex1 = valid_ex1 & ~nuke.valid;

    always_comb begin
        complete_ex1.valid   = live_ex1;
        complete_ex1.mispred = uinstr_ex1.mispred;
        complete_ex1.robid   = robid_ex1;

        iprf_wr_en_ex1       = live_ex1 & (uinstr_ex1.dst_optype == OP_REG);
        iprf_wr_pkt_ex1.pdst = pdst_ex1;
        iprf_wr_pkt_ex1.data = result_ex1;
    end

endmodule

// File: hw/prf.sv
module prf
    import exe_pkg::*;
#(
    parameter int NUM_PREGS = 48
) (
    input  logic         clk,
    input  logic         arst_n,

    input  t_prf_id      rd_id1,
    input  t_prf_id      rd_id2,
    output t_rv_reg_data rd_val1,
    output t_rv_reg_data rd_val2,

    input  logic         wr_en,
    input  t_prf_wr_pkt  wr_pkt
);

    t_rv_reg_data regs [NUM_PREGS];
    logic         wr_ok;

    // Register 0 never takes a write
    assign wr_ok = wr_en && (wr_pkt.pdst != '0) && (int'(wr_pkt.pdst) < NUM_PREGS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wr_pkt.pdst] <= wr_pkt.data;
        end
    end

    function automatic t_rv_reg_data read_port(t_prf_id id);
        t_rv_reg_data val;
        val = '0;
        if (id == '0 || int'(id) >= NUM_PREGS) begin
            val = '0;
        end else if (wr_ok && wr_pkt.pdst == id) begin
            // Same-cycle write bypass
            val = wr_pkt.data;
        end else begin
            val = regs[id];
        end
        return val;
    endfunction

    always_comb begin
        rd_val1 = read_port(rd_id1);
        rd_val2 = read_port(rd_id2);
    end

endmodule

// File: hw/rob_retire.sv
module rob_retire
    import exe_pkg::*;
#(
    parameter int ROB_ENTRIES = 16
) (
    input  logic              clk,
    input  logic              arst_n,

    input  t_rob_complete_pkt complete,
    input  t_br_mispred_pkt   br_mispred,

    output logic              retire_valid,
    output t_rob_id           retire_robid,
    output t_nuke_pkt         nuke
);

    localparam int IDX_W = $clog2(ROB_ENTRIES);

    logic [IDX_W-1:0]       head;
    logic [IDX_W-1:0]       cmpl_idx;
    logic [IDX_W-1:0]       br_idx;
    logic [ROB_ENTRIES-1:0] cmpl_q;
    logic [ROB_ENTRIES-1:0] mispred_q;
    t_rv_reg_data           redir_q [ROB_ENTRIES];

    assign cmpl_idx = complete.robid[IDX_W-1:0];
    assign br_idx   = br_mispred.robid[IDX_W-1:0];

    // Retire straight from the head entry
    always_comb begin
        retire_valid = cmpl_q[head];
        retire_robid = t_rob_id'(head);
        nuke.valid   = cmpl_q[head] & mispred_q[head];
        nuke.pc      = redir_q[head];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head   <= '0;
            cmpl_q <= '0;
        end else if (nuke.valid) begin
            head   <= '0;
            cmpl_q <= '0;
        end else begin
            if (retire_valid) begin
                cmpl_q[head] <= 1'b0;
                head         <= head + IDX_W'(1);
            end
            if (complete.valid) begin
                cmpl_q[cmpl_idx] <= 1'b1;
            end
        end
    end

    // Per-entry mispred flag and redirect pc
    always_ff @(posedge clk) begin
        if (complete.valid) begin
            mispred_q[cmpl_idx] <= complete.mispred;
        end
        if (br_mispred.valid) begin
            redir_q[br_idx] <= br_mispred.target;
        end
    end

endmodule

// File: hw/exe_top.sv
module exe_top
    import exe_pkg::*;
#(
    parameter int NUM_PREGS   = 48,
    parameter int ROB_ENTRIES = 16
) (
    input  logic            clk,
    input  logic            arst_n,

    input  logic            iss_valid,
    input  t_iss_pkt        iss_pkt,

    output t_br_mispred_pkt br_mispred,
    output logic            prf_wr_en,
    output t_prf_wr_pkt     prf_wr_pkt,
    output logic            retire_valid,
    output t_rob_id         retire_robid,
    output t_nuke_pkt       nuke
);

    t_rv_reg_data      src1_val;
    t_rv_reg_data      src2_val;
    t_exe_iss_pkt      exe_iss_pkt;
    t_rob_complete_pkt complete_ex1;

    prf #(
        .NUM_PREGS (NUM_PREGS)
    ) u_prf (
        .clk,
        .arst_n,
        .rd_id1  (iss_pkt.psrc1),
        .rd_id2  (iss_pkt.psrc2),
        .rd_val1 (src1_val),
        .rd_val2 (src2_val),
        .wr_en   (prf_wr_en),
        .wr_pkt  (prf_wr_pkt)
    );

    always_comb begin
        exe_iss_pkt.uinstr       = iss_pkt.uinstr;
        exe_iss_pkt.uinstr.valid = iss_pkt.uinstr.valid & iss_valid;
        exe_iss_pkt.psrc1        = iss_pkt.psrc1;
        exe_iss_pkt.psrc2        = iss_pkt.psrc2;
        exe_iss_pkt.pdst         = iss_pkt.pdst;
        exe_iss_pkt.robid        = iss_pkt.robid;
        exe_iss_pkt.src1_val     = src1_val;
        exe_iss_pkt.src2_val     = src2_val;
    end

    exe u_exe (
        .clk,
        .arst_n,
        .nuke,
        .iss_pkt_ex0     (exe_iss_pkt),
        .br_mispred_ex0  (br_mispred),
        .iprf_wr_en_ex1  (prf_wr_en),
        .iprf_wr_pkt_ex1 (prf_wr_pkt),
        .complete_ex1
    );

    rob_retire #(
        .ROB_ENTRIES (ROB_ENTRIES)
    ) u_rob_retire (
        .clk,
        .arst_n,
        .complete     (complete_ex1),
        .br_mispred,
        .retire_valid,
        .retire_robid,
        .nuke
    );

endmodule

// File: testbench/exe_tb.sv
module exe_tb
    import exe_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_PREGS    = 48;
    localparam int ROB_ENTRIES  = 16;
    localparam int CLK_HALF     = 20;
    localparam int DRIVE_DLY    = 5;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_ALU      = 120;
    localparam int NUM_CHAIN    = 40;
    localparam int NUM_BR       = 80;
    localparam int NUM_NUKE     = 4;
    localparam int NUM_OPS      = NUM_ALU + NUM_CHAIN + NUM_BR + NUM_NUKE;
    // A mispredicted branch also costs a killed op and an empty nuke slot
    localparam int MAX_CYCLES   = RESET_CYCLES + 3 * NUM_OPS + 200;

    typedef struct {
        t_rob_id      robid;
        logic         mispred;
        t_rv_reg_data target;
        int           cycle;
        string        test;
    } t_retire_exp;

    logic            clk;
    logic            arst_n;
    logic            iss_valid;
    t_iss_pkt        iss_pkt;
    t_br_mispred_pkt br_mispred;
    logic            prf_wr_en;
    t_prf_wr_pkt     prf_wr_pkt;
    logic            retire_valid;
    t_rob_id         retire_robid;
    t_nuke_pkt       nuke;

    logic [31:0]     lfsr_state;
    int              cycle_cnt;
    logic            issued_any;
    t_rv_reg_data    shadow [64];
    t_retire_exp     rq [$];
    t_rob_id         next_robid;
    t_prf_id         last_pdst;
    logic            after_flush;
    logic            last_mispred;

    logic            pend_wr_en;
    t_prf_id         pend_wr_pdst;
    t_rv_reg_data    pend_wr_data;
    string           pend_wr_test;
    logic            exp_wr_en;
    t_prf_id         exp_wr_pdst;
    t_rv_reg_data    exp_wr_data;
    string           exp_wr_test;
    logic            exp_mp_valid;
    t_rob_id         exp_mp_robid;
    t_rv_reg_data    exp_mp_target;
    string           exp_mp_test;

    exe_top #(
        .NUM_PREGS   (NUM_PREGS),
        .ROB_ENTRIES (ROB_ENTRIES)
    ) dut0 (
        .clk,
        .arst_n,
        .iss_valid,
        .iss_pkt,
        .br_mispred,
        .prf_wr_en,
        .prf_wr_pkt,
        .retire_valid,
        .retire_robid,
        .nuke
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR %s: %s expected 0x%08h, actual 0x%08h", test, what, exp, act);
        abort_run();
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR: %s", msg);
        abort_run();
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_step()};
        end
        return val;
    endfunction

    function automatic t_rv_reg_data alu_ref(input t_uop op, input t_rv_reg_data a,
                                             input t_rv_reg_data b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        sa = a;
        sb = b;
        case (op)
            U_ADD:   return a + b;
            U_SUB:   return a - b;
            U_AND:   return a & b;
            U_OR:    return a | b;
            U_XOR:   return a ^ b;
            U_SLL:   return a << b[4:0];
            U_SRL:   return a >> b[4:0];
            U_SRA:   return sa >>> b[4:0];
            U_SLT:   return (sa < sb) ? 32'd1 : 32'd0;
            U_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input t_uop op, input t_rv_reg_data a,
                                          input t_rv_reg_data b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        sa = a;
        sb = b;
        case (op)
            U_BEQ:   return a == b;
            U_BNE:   return a != b;
            U_BLT:   return sa < sb;
            U_BGE:   return !(sa < sb);
            U_BLTU:  return a < b;
            U_BGEU:  return !(a < b);
            U_JAL:   return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic t_iss_pkt rand_op(input logic branch, input logic chain);
        t_iss_pkt    pkt;
        logic [31:0] r;
        pkt = '0;
        pkt.uinstr.valid = 1'b1;
        r = rand_bits(30);
        pkt.uinstr.pc = {r[29:0], 2'b00};
        if (chain || after_flush || rand_bits(2) == 0) begin
            pkt.psrc1 = last_pdst;
        end else begin
            pkt.psrc1 = t_prf_id'(rand_bits(6) % NUM_PREGS);
        end
        pkt.psrc2 = t_prf_id'(rand_bits(6) % NUM_PREGS);
        pkt.pdst  = t_prf_id'(rand_bits(6) % NUM_PREGS);
        pkt.robid = next_robid;
        r = rand_bits(12);
        if (branch) begin
            pkt.uinstr.uop        = t_uop'(5'(10 + rand_bits(3) % 7));
            pkt.uinstr.imm        = {{19{r[11]}}, r[11:0], 1'b0};
            pkt.uinstr.pred_taken = lfsr_step();
            if (pkt.uinstr.uop == U_JAL) begin
                pkt.uinstr.src2_optype = OP_NONE;
                pkt.uinstr.dst_optype  = OP_REG;
            end else begin
                pkt.uinstr.src2_optype = OP_REG;
                pkt.uinstr.dst_optype  = OP_NONE;
            end
            // Equal operands so BEQ and BGE see both outcomes
            if (rand_bits(2) == 0) begin
                pkt.psrc2 = pkt.psrc1;
            end
        end else begin
            pkt.uinstr.uop         = t_uop'(5'(rand_bits(4) % 10));
            pkt.uinstr.imm         = {{20{r[11]}}, r[11:0]};
            pkt.uinstr.src2_optype = lfsr_step() ? OP_IMM : OP_REG;
            pkt.uinstr.dst_optype  = (rand_bits(3) == 0) ? OP_NONE : OP_REG;
        end
        return pkt;
    endfunction

    // Last cycle's issue becomes this cycle's expected write
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        exp_wr_en    = pend_wr_en;
        exp_wr_pdst  = pend_wr_pdst;
        exp_wr_data  = pend_wr_data;
        exp_wr_test  = pend_wr_test;
        pend_wr_en   = 1'b0;
        exp_mp_valid = 1'b0;
    endtask

    task automatic idle_cycle();
        next_cycle();
        iss_valid = 1'b0;
        iss_pkt   = '0;
    endtask

    task automatic issue_op(input t_iss_pkt pkt, input string test, input logic killed);
        t_rv_reg_data a;
        t_rv_reg_data b;
        t_rv_reg_data res;
        logic         taken;
        logic         is_br;
        t_retire_exp  ent;
        next_cycle();
        iss_valid  = 1'b1;
        iss_pkt    = pkt;
        issued_any = 1'b1;

        a = shadow[pkt.psrc1];
        case (pkt.uinstr.src2_optype)
            OP_REG:  b = shadow[pkt.psrc2];
            OP_IMM:  b = pkt.uinstr.imm;
            default: b = '0;
        endcase
        is_br = pkt.uinstr.uop inside {U_BEQ, U_BNE, U_BLT, U_BGE, U_BLTU, U_BGEU, U_JAL};
        taken = branch_taken(pkt.uinstr.uop, a, b);
        res   = (pkt.uinstr.uop == U_JAL) ? pkt.uinstr.pc + 32'd4
                                          : alu_ref(pkt.uinstr.uop, a, b);

        exp_mp_valid  = is_br && (taken != pkt.uinstr.pred_taken);
        exp_mp_robid  = pkt.robid;
        exp_mp_target = taken ? pkt.uinstr.pc + pkt.uinstr.imm : pkt.uinstr.pc + 32'd4;
        exp_mp_test   = test;
        last_mispred  = exp_mp_valid;
        pend_wr_test  = test;

        if (!killed) begin
            pend_wr_en   = (pkt.uinstr.dst_optype == OP_REG);
            pend_wr_pdst = pkt.pdst;
            pend_wr_data = res;
            if (pend_wr_en && pkt.pdst != '0) begin
                shadow[pkt.pdst] = res;
            end
            ent.robid   = pkt.robid;
            ent.mispred = exp_mp_valid;
            ent.target  = exp_mp_target;
            ent.cycle   = cycle_cnt;
            ent.test    = test;
            rq.push_back(ent);
        end
        last_pdst   = pkt.pdst;
        after_flush = 1'b0;
        next_robid  = t_rob_id'((int'(next_robid) + 1) % ROB_ENTRIES);
    endtask

    task automatic run_op(input t_iss_pkt pkt, input string test);
        t_iss_pkt younger;
        issue_op(pkt, test, 1'b0);
        if (last_mispred) begin
            // Younger op sits in EX1 when the nuke fires
            younger = rand_op(1'b0, 1'b0);
            younger.uinstr.uop         = U_ADD;
            younger.uinstr.src2_optype = OP_IMM;
            younger.uinstr.dst_optype  = OP_REG;
            younger.uinstr.imm         = 32'h0000_0155;
            if (younger.pdst == '0) begin
                younger.pdst = 6'd1;
            end
            issue_op(younger, test, 1'b1);
            idle_cycle();
            next_robid  = '0;
            after_flush = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            report_problem("timeout, the run went past its cycle limit");
        end
    end

    // Nothing leaves the cluster before the first issue
    assert property (@(posedge clk)
        !issued_any |-> !(prf_wr_en || retire_valid || nuke.valid || br_mispred.valid))
        else report_problem("valid output seen during reset or before the first issue");

    assert property (@(posedge clk) disable iff (!arst_n) nuke.valid |=> !nuke.valid)
        else report_problem("nuke held for more than one cycle");

    always @(negedge clk) begin
        if (arst_n) begin
            assert (prf_wr_en == exp_wr_en)
                else report_mismatch(exp_wr_test, "prf write enable",
                                     32'(exp_wr_en), 32'(prf_wr_en));
            if (exp_wr_en) begin
                assert (prf_wr_pkt.pdst == exp_wr_pdst)
                    else report_mismatch(exp_wr_test, "prf write pdst",
                                         32'(exp_wr_pdst), 32'(prf_wr_pkt.pdst));
                assert (prf_wr_pkt.data == exp_wr_data)
                    else report_mismatch(exp_wr_test, "prf write data",
                                         exp_wr_data, prf_wr_pkt.data);
            end

            assert (br_mispred.valid == exp_mp_valid)
                else report_mismatch(exp_mp_test, "br_mispred valid",
                                     32'(exp_mp_valid), 32'(br_mispred.valid));
            if (exp_mp_valid) begin
                assert (br_mispred.robid == exp_mp_robid)
                    else report_mismatch(exp_mp_test, "br_mispred robid",
                                         32'(exp_mp_robid), 32'(br_mispred.robid));
                assert (br_mispred.target == exp_mp_target)
                    else report_mismatch(exp_mp_test, "br_mispred target",
                                         exp_mp_target, br_mispred.target);
            end

            if (retire_valid) begin
                if (rq.size() == 0) begin
                    report_problem("retire seen with no operation outstanding");
                end else begin
                    assert (retire_robid == rq[0].robid)
                        else report_mismatch(rq[0].test, "retire robid",
                                             32'(rq[0].robid), 32'(retire_robid));
                    assert (cycle_cnt >= rq[0].cycle + 2)
                        else report_mismatch(rq[0].test, "earliest retire cycle",
                                             32'(rq[0].cycle + 2), 32'(cycle_cnt));
                    assert (nuke.valid == rq[0].mispred)
                        else report_mismatch(rq[0].test, "nuke valid",
                                             32'(rq[0].mispred), 32'(nuke.valid));
                    if (rq[0].mispred) begin
                        assert (nuke.pc == rq[0].target)
                            else report_mismatch(rq[0].test, "nuke redirect pc",
                                                 rq[0].target, nuke.pc);
                    end
                    void'(rq.pop_front());
                end
            end else begin
                assert (!nuke.valid)
                    else report_problem("nuke raised without a retire");
            end
        end
    end

    initial begin
        t_iss_pkt pkt;
        arst_n       = 1'b0;
        iss_valid    = 1'b0;
        iss_pkt      = '0;
        lfsr_state   = 32'h3648_ae0a;
        issued_any   = 1'b0;
        next_robid   = '0;
        last_pdst    = '0;
        after_flush  = 1'b0;
        last_mispred = 1'b0;
        pend_wr_en   = 1'b0;
        pend_wr_pdst = '0;
        pend_wr_data = '0;
        exp_wr_en    = 1'b0;
        exp_wr_pdst  = '0;
        exp_wr_data  = '0;
        exp_mp_valid = 1'b0;
        exp_mp_robid = '0;
        exp_mp_target = '0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        repeat (3) idle_cycle();

        for (int i = 0; i < NUM_ALU; i++) begin
            run_op(rand_op(1'b0, 1'b0), "alu");
        end

        // Back to back through the bypass with the first link writing register 0
        for (int i = 0; i < NUM_CHAIN; i++) begin
            pkt = rand_op(1'b0, 1'b1);
            pkt.uinstr.dst_optype = OP_REG;
            if (i == 0) begin
                pkt.pdst = '0;
            end
            run_op(pkt, "chain");
        end

        for (int i = 0; i < NUM_BR; i++) begin
            run_op(rand_op(1'b1, 1'b0), "branch");
        end

        // Taken BEQ predicted not taken
        pkt = rand_op(1'b1, 1'b0);
        pkt.uinstr.uop         = U_BEQ;
        pkt.uinstr.src2_optype = OP_REG;
        pkt.uinstr.dst_optype  = OP_NONE;
        pkt.uinstr.pred_taken  = 1'b0;
        pkt.psrc2              = pkt.psrc1;
        run_op(pkt, "nuke");
        run_op(rand_op(1'b0, 1'b0), "nuke");

        pkt = rand_op(1'b1, 1'b0);
        pkt.uinstr.uop         = U_JAL;
        pkt.uinstr.src2_optype = OP_NONE;
        pkt.uinstr.dst_optype  = OP_REG;
        pkt.uinstr.pred_taken  = 1'b0;
        run_op(pkt, "nuke");
        run_op(rand_op(1'b0, 1'b0), "nuke");

        while (rq.size() != 0) begin
            idle_cycle();
        end
        repeat (4) idle_cycle();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verilog.f
hw/exe_pkg.sv
hw/ialu.sv
hw/ibr.sv
hw/exe.sv
hw/prf.sv
hw/rob_retire.sv
hw/exe_top.sv
testbench/exe_tb.sv
